// File: bench/tb_xsleena_io.sv
/* Directed testbench for the cabinet I/O block; tasks drive each function and
   compare against a model, with a four-phase responder on the PLL port. */
`timescale 1ns/1ps
`default_nettype none

module tb_xsleena_io;

	logic MS_CLK = 1'b0;
	logic reset;
	xs_pkg::joy_word_t joystick_0;
	xs_pkg::joy_word_t joystick_1;
	xs_pkg::joy_word_t db15_1;
	xs_pkg::joy_word_t db15_2;
	logic [1:0] snac_dev;
	xs_pkg::ps2_key_t ps2_key;
	xs_pkg::dl_write_t dl;
	xs_pkg::video_timing_e timing_sel;
	logic pll_locked;
	logic cfg_ack = 1'b0;
	xs_pkg::port_byte_t player1;
	xs_pkg::port_byte_t player2;
	logic pause_btn;
	xs_pkg::port_byte_t dsw1;
	xs_pkg::port_byte_t dsw2;
	xs_pkg::pll_cfg_t cfg;
	logic cfg_req;
	logic reconfig_pause;
	logic init_done;

	int seed = 32'h9ab88693;

	// Keyboard model: held keys as the ports should see them
	logic [5:0] kb_moves;
	logic kb_start1;
	logic kb_start2;
	logic kb_coin1;
	logic kb_coin2;
	logic kb_pause;

	// PLL responder state and write log
	int ack_wait = -1;
	xs_pkg::pll_cfg_t req_cfg;
	xs_pkg::pll_cfg_t cfg_log [$];

	always #5 MS_CLK = ~MS_CLK;

	xsleena_io i_xsleena_io (
		.MS_CLK(MS_CLK),
		.reset(reset),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.db15_1(db15_1),
		.db15_2(db15_2),
		.snac_dev(snac_dev),
		.ps2_key(ps2_key),
		.dl(dl),
		.timing_sel(timing_sel),
		.pll_locked(pll_locked),
		.cfg_ack(cfg_ack),
		.player1(player1),
		.player2(player2),
		.pause_btn(pause_btn),
		.dsw1(dsw1),
		.dsw2(dsw2),
		.cfg(cfg),
		.cfg_req(cfg_req),
		.reconfig_pause(reconfig_pause),
		.init_done(init_done)
	);

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// Fixed edge count, then sample mid-cycle
	task automatic settle_edges(int n);
		repeat (n) @(posedge MS_CLK);
		@(negedge MS_CLK);
	endtask

	////////////////////
	// PLL port responder
	////////////////////
	// Acks 1 to 6 cycles after req, drops ack once req is gone
	always @(negedge MS_CLK) begin
		if (reset) begin
			cfg_ack = 1'b0;
			ack_wait = -1;
		end else if (cfg_req && !cfg_ack) begin
			if (ack_wait < 0) begin
				ack_wait = 1 + int'($unsigned($random(seed)) % 6);
				req_cfg = cfg;
			end
			ack_wait = ack_wait - 1;
			if (ack_wait == 0) begin
				assert (cfg === req_cfg) else
					fail_run($sformatf("ERROR: cfg changed under req, got %h expected %h",
						cfg, req_cfg));
				assert (reconfig_pause === 1'b1) else
					fail_run("PLL write requested while the core was not paused");
				$display("PLL write addr %h data %h", cfg.addr, cfg.data);
				cfg_log.push_back(cfg);
				cfg_ack = 1'b1;
				ack_wait = -1;
			end
		end else if (!cfg_req && cfg_ack) begin
			cfg_ack = 1'b0;
		end
	end

	////////////////////
	// Port model
	////////////////////
	// Returns {pause_btn, player2, player1} from the current stimulus
	function automatic logic [16:0] expected_ports();
		xs_pkg::joy_word_t db0;
		xs_pkg::joy_word_t db1;
		logic [5:0] moves0;
		logic [5:0] moves1;
		logic start1;
		logic start2;
		logic coin0;
		logic coin1;
		logic pause;
		logic [7:0] port1;
		logic [7:0] port2;
		db0 = snac_dev[0] ? db15_1 : '0;
		db1 = snac_dev[1] ? db15_2 : '0;
		moves0 = joystick_0[5:0] | db0[5:0] | kb_moves;
		moves1 = joystick_1[5:0] | db1[5:0] | kb_moves;
		// Shared start lines, DB15 start goes to its own player
		start1 = joystick_0[6] | joystick_1[6] | kb_start1 | db0[10];
		start2 = joystick_0[8] | joystick_1[8] | kb_start2 | db1[10];
		coin0 = joystick_0[7] | db0[11] | kb_coin1;
		coin1 = joystick_1[7] | db1[11] | kb_coin2;
		pause = joystick_0[9] | joystick_1[9] | kb_pause;
		pause = pause | (db0[4] & db0[10]) | (db1[4] & db1[10]);
		// Port bytes put down above up, the joystick word has up above down
		port1 = {start2, start1, moves0[5], moves0[4], moves0[2], moves0[3],
			moves0[1], moves0[0]};
		port2 = {coin1, coin0, moves1[5], moves1[4], moves1[2], moves1[3],
			moves1[1], moves1[0]};
		return {pause, ~port2, ~port1};
	endfunction

	task automatic check_ports();
		logic [16:0] exp;
		exp = expected_ports();
		assert (player1 === exp[7:0]) else
			fail_run($sformatf("ERROR: player1 got %h expected %h", player1, exp[7:0]));
		assert (player2 === exp[15:8]) else
			fail_run($sformatf("ERROR: player2 got %h expected %h", player2, exp[15:8]));
		assert (pause_btn === exp[16]) else
			fail_run($sformatf("ERROR: pause_btn got %h expected %h", pause_btn, exp[16]));
	endtask

	// New PS/2 event, model follows the keyboard rule
	task automatic send_key(logic [7:0] code, logic make);
		ps2_key.toggle = ~ps2_key.toggle;
		ps2_key.pressed = make;
		ps2_key.ext = 1'b0;
		ps2_key.code = code;
		case (code)
			xs_pkg::KEY_RIGHT: kb_moves[0] = make;
			xs_pkg::KEY_LEFT: kb_moves[1] = make;
			xs_pkg::KEY_DOWN: kb_moves[2] = make;
			xs_pkg::KEY_UP: kb_moves[3] = make;
			xs_pkg::KEY_CTRL: kb_moves[4] = make;
			xs_pkg::KEY_ALT: kb_moves[5] = make;
			xs_pkg::KEY_START1: kb_start1 = make;
			xs_pkg::KEY_START2: kb_start2 = make;
			xs_pkg::KEY_COIN1: kb_coin1 = make;
			xs_pkg::KEY_COIN2: kb_coin2 = make;
			xs_pkg::KEY_PAUSE: kb_pause = make;
			// Service is decoded but reaches no port
			default: ;
		endcase
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic test_reset_state();
		check_ports();
		assert (dsw1 === 8'hFF) else
			fail_run($sformatf("ERROR: dsw1 got %h expected %h", dsw1, 8'hFF));
		assert (dsw2 === 8'hFF) else
			fail_run($sformatf("ERROR: dsw2 got %h expected %h", dsw2, 8'hFF));
		assert (cfg_req === 1'b0) else
			fail_run($sformatf("ERROR: cfg_req got %h expected %h", cfg_req, 1'b0));
		assert (reconfig_pause === 1'b0) else
			fail_run($sformatf("ERROR: reconfig_pause got %h expected %h",
				reconfig_pause, 1'b0));
		assert (init_done === 1'b0) else
			fail_run($sformatf("ERROR: init_done got %h expected %h", init_done, 1'b0));
	endtask

	task automatic test_merge();
		for (int i = 0; i < 200; i++) begin
			joystick_0 = 16'($random(seed));
			joystick_1 = 16'($random(seed));
			db15_1 = 16'($random(seed));
			db15_2 = 16'($random(seed));
			snac_dev = 2'($random(seed));
			// Every fourth pair with both DB15 ports off
			if (i % 4 == 0) begin
				snac_dev = 2'b00;
			end
			settle_edges(2);
			check_ports();
		end
		joystick_0 = '0;
		joystick_1 = '0;
		db15_1 = '0;
		db15_2 = '0;
		snac_dev = 2'b00;
		settle_edges(2);
		check_ports();
	endtask

	task automatic test_keyboard();
		logic [7:0] codes [12];
		logic [16:0] idle;
		idle = {1'b0, 8'hFF, 8'hFF};
		codes = '{xs_pkg::KEY_START1, xs_pkg::KEY_START2, xs_pkg::KEY_COIN1,
			xs_pkg::KEY_COIN2, xs_pkg::KEY_SERVICE, xs_pkg::KEY_PAUSE,
			xs_pkg::KEY_UP, xs_pkg::KEY_DOWN, xs_pkg::KEY_LEFT,
			xs_pkg::KEY_RIGHT, xs_pkg::KEY_CTRL, xs_pkg::KEY_ALT};
		foreach (codes[i]) begin
			send_key(codes[i], 1'b1);
			settle_edges(3);
			check_ports();
			if (codes[i] != xs_pkg::KEY_SERVICE) begin
				assert ({pause_btn, player2, player1} !== idle) else
					fail_run($sformatf("Key %h press moved no port bit", codes[i]));
			end
			send_key(codes[i], 1'b0);
			settle_edges(3);
			check_ports();
		end
		// Unknown scan code
		send_key(8'h5A, 1'b1);
		settle_edges(3);
		check_ports();
		// Same toggle, so no event even with a known code
		ps2_key.pressed = 1'b1;
		ps2_key.code = xs_pkg::KEY_LEFT;
		settle_edges(3);
		check_ports();
		ps2_key.code = 8'h00;
	endtask

	task automatic write_dip(logic [7:0] index, int addr, logic [7:0] data);
		dl.wr = 1'b1;
		dl.index = index;
		dl.addr = xs_pkg::dl_addr_t'(addr);
		dl.data = data;
		@(posedge MS_CLK);
		@(negedge MS_CLK);
		dl.wr = 1'b0;
	endtask

	task automatic check_dip(logic [7:0] exp1, logic [7:0] exp2);
		assert (dsw1 === exp1) else
			fail_run($sformatf("ERROR: dsw1 got %h expected %h", dsw1, exp1));
		assert (dsw2 === exp2) else
			fail_run($sformatf("ERROR: dsw2 got %h expected %h", dsw2, exp2));
	endtask

	task automatic test_dip();
		logic [7:0] d1;
		logic [7:0] d2;
		d1 = 8'($random(seed));
		d2 = 8'($random(seed));
		write_dip(xs_pkg::DIP_INDEX, 0, d1);
		check_dip(d1, 8'hFF);
		write_dip(xs_pkg::DIP_INDEX, 1, d2);
		check_dip(d1, d2);
		// Wrong index, then an unused DIP byte
		write_dip(8'd253, 0, ~d1);
		check_dip(d1, d2);
		write_dip(xs_pkg::DIP_INDEX, 2, ~d2);
		check_dip(d1, d2);
	endtask

	task automatic wait_pause(logic level, int limit);
		int n;
		n = 0;
		while (reconfig_pause !== level && n < limit) begin
			@(negedge MS_CLK);
			n++;
		end
		assert (reconfig_pause === level) else
			fail_run($sformatf("Timed out waiting for reconfig_pause to go %0d", level));
	endtask

	task automatic check_table(xs_pkg::video_timing_e sel);
		xs_pkg::pll_cfg_t exp;
		assert (cfg_log.size() == xs_pkg::PLL_PARAM_COUNT) else
			fail_run($sformatf("ERROR: PLL write count got %h expected %h",
				cfg_log.size(), xs_pkg::PLL_PARAM_COUNT));
		for (int i = 0; i < xs_pkg::PLL_PARAM_COUNT; i++) begin
			exp = (sel == xs_pkg::VIDEO_60HZ) ? xs_pkg::PLL_TABLE_60[i] :
				xs_pkg::PLL_TABLE_57[i];
			assert (cfg_log[i] === exp) else
				fail_run($sformatf("ERROR: cfg write %0d got %h expected %h",
					i, cfg_log[i], exp));
		end
	endtask

	task automatic run_timing_change(xs_pkg::video_timing_e sel);
		cfg_log.delete();
		timing_sel = sel;
		wait_pause(1'b1, 5);
		wait_pause(1'b0, 2000);
		check_table(sel);
	endtask

	task automatic test_pll();
		// Lock with the reset timing, nothing to write
		pll_locked = 1'b1;
		settle_edges(4);
		assert (init_done === 1'b1) else
			fail_run($sformatf("ERROR: init_done got %h expected %h", init_done, 1'b1));
		assert (reconfig_pause === 1'b0 && cfg_log.size() == 0) else
			fail_run("A PLL sequence started without a timing change");
		run_timing_change(xs_pkg::VIDEO_60HZ);
		run_timing_change(xs_pkg::VIDEO_57HZ);
		// Without lock the change has to wait
		pll_locked = 1'b0;
		cfg_log.delete();
		timing_sel = xs_pkg::VIDEO_60HZ;
		for (int n = 0; n < 300; n++) begin
			@(negedge MS_CLK);
			assert (cfg_req === 1'b0 && reconfig_pause === 1'b0) else
				fail_run("PLL sequence moved while pll_locked was low");
		end
		pll_locked = 1'b1;
		wait_pause(1'b1, 5);
		wait_pause(1'b0, 2000);
		check_table(xs_pkg::VIDEO_60HZ);
	endtask

	initial begin
		reset = 1'b1;
		joystick_0 = '0;
		joystick_1 = '0;
		db15_1 = '0;
		db15_2 = '0;
		snac_dev = 2'b00;
		ps2_key = '0;
		dl = '0;
		timing_sel = xs_pkg::VIDEO_57HZ;
		pll_locked = 1'b0;
		kb_moves = '0;
		kb_start1 = 1'b0;
		kb_start2 = 1'b0;
		kb_coin1 = 1'b0;
		kb_coin2 = 1'b0;
		kb_pause = 1'b0;
		repeat (2) @(posedge MS_CLK);
		@(negedge MS_CLK);
		reset = 1'b0;

		test_reset_state();
		test_merge();
		test_keyboard();
		test_dip();
		test_pll();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status carries pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal \
	--top-module tb_xsleena_io \
	-f sources.f \
	-o sim_xsleena_io

./obj_dir/sim_xsleena_io

// File: sources.f
verilog/xs_pkg.sv
verilog/key_decoder.sv
verilog/player_merge.sv
verilog/cabinet_ports.sv
verilog/dip_capture.sv
verilog/pll_reprogram.sv
verilog/xsleena_io.sv
bench/tb_xsleena_io.sv

// File: verilog/cabinet_ports.sv
/* Packs both players' merged controls into the active-low cabinet port
   bytes and the active-high pause request, all registered. */
`timescale 1ns/1ps
`default_nettype none

module cabinet_ports (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::pressed_t [xs_pkg::NUM_PLAYERS-1:0] pressed,
	output xs_pkg::port_byte_t player1,
	output xs_pkg::port_byte_t player2,
	output logic pause_btn
);

	logic start1;
	logic start2;
	xs_pkg::port_byte_t p1_high;
	xs_pkg::port_byte_t p2_high;

	// One set of start lines shared by both players
	// A DB15 start goes to its own player's start
	assign start1 = pressed[0].start1 | pressed[1].start1 | pressed[0].start_own;
	assign start2 = pressed[0].start2 | pressed[1].start2 | pressed[1].start_own;

	// Port 1: 2P start, 1P start, then player 0 controls
	assign p1_high = {
		start2,
		start1,
		pressed[0].jump,
		pressed[0].shot,
		pressed[0].down,
		pressed[0].up,
		pressed[0].left,
		pressed[0].right
	};

	// Port 2: coin 2, coin 1, then player 1 controls
	assign p2_high = {
		pressed[1].coin,
		pressed[0].coin,
		pressed[1].jump,
		pressed[1].shot,
		pressed[1].down,
		pressed[1].up,
		pressed[1].left,
		pressed[1].right
	};

	////////////////////
	// Output registers
	////////////////////
	// Board inputs are active low, pause stays active high
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			player1 <= 8'hFF;
			player2 <= 8'hFF;
			pause_btn <= 1'b0;
		end else begin
			player1 <= ~p1_high;
			player2 <= ~p2_high;
			pause_btn <= pressed[0].pause | pressed[1].pause;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dip_capture.sv
/* Takes DIP switch bytes 0 and 1 from the download stream at the DIP
   index and holds them for the board. */
`timescale 1ns/1ps
`default_nettype none

module dip_capture (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::dl_write_t dl,
	output xs_pkg::port_byte_t dsw1,
	output xs_pkg::port_byte_t dsw2
);

	logic dip_write;

	// Write strobe aimed at the DIP block
	assign dip_write = dl.wr && (dl.index == xs_pkg::DIP_INDEX);

	// Address 0 is DSW1, address 1 is DSW2
	// Higher DIP bytes are not used by this board
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			// All switches off, active low
			dsw1 <= 8'hFF;
			dsw2 <= 8'hFF;
		end else if (dip_write) begin
			if (dl.addr == xs_pkg::dl_addr_t'(0)) begin
				dsw1 <= dl.data;
			end
			if (dl.addr == xs_pkg::dl_addr_t'(1)) begin
				dsw2 <= dl.data;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/key_decoder.sv
/* PS/2 key event decoder; holds a state per key and fans the keys out
   into one held-button view per player. */
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::ps2_key_t ps2_key,
	output xs_pkg::key_player_t [xs_pkg::NUM_PLAYERS-1:0] key_player
);

	logic prev_toggle;
	logic key_event;
	logic key_start1, key_start2, key_coin1, key_coin2;
	logic key_service, key_pause;
	logic key_up, key_down, key_left, key_right;
	logic key_shot, key_jump;

	// A new event flips the toggle bit
	assign key_event = ps2_key.toggle != prev_toggle;

	// Tracked every cycle, so reset leaves no false event behind
	always_ff @(posedge MS_CLK) begin
		prev_toggle <= ps2_key.toggle;
	end

	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			key_start1 <= 1'b0;
			key_start2 <= 1'b0;
			key_coin1 <= 1'b0;
			key_coin2 <= 1'b0;
			key_service <= 1'b0;
			key_pause <= 1'b0;
			key_up <= 1'b0;
			key_down <= 1'b0;
			key_left <= 1'b0;
			key_right <= 1'b0;
			key_shot <= 1'b0;
			key_jump <= 1'b0;
		end else if (key_event) begin
			// Make or break sets the held state
			case (ps2_key.code)
				xs_pkg::KEY_START1: key_start1 <= ps2_key.pressed;
				xs_pkg::KEY_START2: key_start2 <= ps2_key.pressed;
				xs_pkg::KEY_COIN1: key_coin1 <= ps2_key.pressed;
				xs_pkg::KEY_COIN2: key_coin2 <= ps2_key.pressed;
				xs_pkg::KEY_SERVICE: key_service <= ps2_key.pressed;
				xs_pkg::KEY_PAUSE: key_pause <= ps2_key.pressed;
				xs_pkg::KEY_UP: key_up <= ps2_key.pressed;
				xs_pkg::KEY_DOWN: key_down <= ps2_key.pressed;
				xs_pkg::KEY_LEFT: key_left <= ps2_key.pressed;
				xs_pkg::KEY_RIGHT: key_right <= ps2_key.pressed;
				xs_pkg::KEY_CTRL: key_shot <= ps2_key.pressed;
				xs_pkg::KEY_ALT: key_jump <= ps2_key.pressed;
				// Unknown codes ignored
				default: ;
			endcase
		end
	end

	////////////////////
	// Per-player views
	////////////////////
	// Shared keys go to both players, coin keys are split
	always_comb begin
		for (int p = 0; p < xs_pkg::NUM_PLAYERS; p++) begin
			key_player[p].right = key_right;
			key_player[p].left = key_left;
			key_player[p].down = key_down;
			key_player[p].up = key_up;
			key_player[p].shot = key_shot;
			key_player[p].jump = key_jump;
			key_player[p].start1 = key_start1;
			key_player[p].start2 = key_start2;
			key_player[p].coin = (p == 0) ? key_coin1 : key_coin2;
			key_player[p].pause = key_pause;
			key_player[p].service = key_service;
		end
	end

endmodule

`default_nettype wire

// File: verilog/player_merge.sv
/* One player's input merge: keyboard, USB joystick and gated DB15 word
   combined into a registered set of active-high controls. */
`timescale 1ns/1ps
`default_nettype none

module player_merge (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::key_player_t key_in,
	input xs_pkg::joy_word_t joystick,
	input xs_pkg::joy_word_t db15,
	input wire logic db_enable,
	output xs_pkg::pressed_t pressed
);

	xs_pkg::joy_word_t db;
	xs_pkg::pressed_t merged;

	// DB15 port off reads as nothing pressed
	assign db = db_enable ? db15 : '0;

	always_comb begin
		// Directions and buttons from all three sources
		merged.right = key_in.right | joystick[0] | db[0];
		merged.left = key_in.left | joystick[1] | db[1];
		merged.down = key_in.down | joystick[2] | db[2];
		merged.up = key_in.up | joystick[3] | db[3];
		merged.shot = key_in.shot | joystick[4] | db[4];
		merged.jump = key_in.jump | joystick[5] | db[5];

		// DB15 start belongs to this player's own start line
		merged.start_own = db[10];
		merged.start1 = joystick[6] | key_in.start1;
		merged.start2 = joystick[8] | key_in.start2;

		// DB15 select acts as coin
		merged.coin = joystick[7] | db[11] | key_in.coin;

		// Start + A chord on DB15 requests pause
		merged.pause = joystick[9] | (db[4] & db[10]) | key_in.pause;
	end

	////////////////////
	// Output register
	////////////////////
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			pressed <= '0;
		end else begin
			pressed <= merged;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pll_reprogram.sv
/* PLL reprogramming sequencer. On a video timing change it pauses, settles,
   then writes the selected table over a four-phase req/ack port. */
`timescale 1ns/1ps
`default_nettype none

module pll_reprogram (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::video_timing_e timing_sel,
	input wire logic pll_locked,
	output xs_pkg::pll_cfg_t cfg,
	output logic cfg_req,
	input wire logic cfg_ack,
	output logic reconfig_pause,
	output logic init_done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SETTLE,
		ST_REQUEST,
		ST_RELEASE,
		ST_RELOCK
	} state_e;

	state_e state;
	xs_pkg::video_timing_e timing_lat;
	xs_pkg::settle_cnt_t settle_cnt;
	xs_pkg::pll_idx_t param_idx;
	logic last_param;

	// Table entry for the current write
	// Index and timing only move while no request is up
	always_comb begin
		if (timing_lat == xs_pkg::VIDEO_60HZ) begin
			cfg = xs_pkg::PLL_TABLE_60[param_idx];
		end else begin
			cfg = xs_pkg::PLL_TABLE_57[param_idx];
		end
	end

	assign last_param = param_idx == xs_pkg::pll_idx_t'(xs_pkg::PLL_PARAM_COUNT - 1);

	////////////////////
	// Sequencer FSM
	////////////////////
	always_ff @(posedge MS_CLK) begin
		if (reset) begin
			state <= ST_IDLE;
			timing_lat <= xs_pkg::VIDEO_57HZ;
			settle_cnt <= '0;
			param_idx <= '0;
			cfg_req <= 1'b0;
			reconfig_pause <= 1'b0;
			init_done <= 1'b0;
		end else if (pll_locked) begin
			// Nothing moves without lock
			init_done <= 1'b1;
			case (state)
				ST_IDLE: begin
					// New timing: latch it and hold the core
					if (timing_sel != timing_lat) begin
						timing_lat <= timing_sel;
						reconfig_pause <= 1'b1;
						settle_cnt <= '0;
						state <= ST_SETTLE;
					end
				end
				ST_SETTLE: begin
					if (settle_cnt == xs_pkg::settle_cnt_t'(xs_pkg::SETTLE_CYCLES - 1)) begin
						param_idx <= '0;
						cfg_req <= 1'b1;
						state <= ST_REQUEST;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				ST_REQUEST: begin
					// Hold req and cfg until the port acks
					if (cfg_ack) begin
						cfg_req <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// Ack must drop before the next pair
					if (!cfg_ack) begin
						if (last_param) begin
							state <= ST_RELOCK;
						end else begin
							param_idx <= param_idx + 1'b1;
							cfg_req <= 1'b1;
							state <= ST_REQUEST;
						end
					end
				end
				ST_RELOCK: begin
					// Locked again, release the core
					reconfig_pause <= 1'b0;
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/xs_pkg.sv
/* Shared widths, types, key codes and PLL tables for the cabinet I/O block.
   Every RTL file refers to these by scoped name. */
`default_nettype none

package xs_pkg;

	////////////////////
	// Widths and plain vector types
	////////////////////
	localparam int NUM_PLAYERS = 2;
	localparam int PLL_PARAM_COUNT = 9;
	// Idle cycles before the first PLL write
	localparam int SETTLE_CYCLES = 255;
	localparam logic [7:0] DIP_INDEX = 8'd254;

	// Joystick/DB15 word: 0..5 R,L,D,U,shot,jump; 6 st1, 7 coin, 8 st2, 9 pause
	// DB15 only: 10 start, 11 coin
	typedef logic [15:0] joy_word_t;
	// Active-low port or DIP byte
	typedef logic [7:0] port_byte_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [5:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;
	typedef logic [$clog2(PLL_PARAM_COUNT)-1:0] pll_idx_t;
	typedef logic [7:0] settle_cnt_t;

	////////////////////
	// Structs
	////////////////////
	typedef struct packed {
		logic toggle;
		logic pressed;
		logic ext;
		logic [7:0] code;
	} ps2_key_t;

	// Held keyboard buttons, one player's view
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic shot;
		logic jump;
		logic start1;
		logic start2;
		logic coin;
		logic pause;
		logic service;
	} key_player_t;

	// Merged controls, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic shot;
		logic jump;
		logic start_own;
		logic start1;
		logic start2;
		logic coin;
		logic pause;
	} pressed_t;

	typedef struct packed {
		logic wr;
		logic [7:0] index;
		dl_addr_t addr;
		logic [7:0] data;
	} dl_write_t;

	typedef struct packed {
		cfg_addr_t addr;
		cfg_data_t data;
	} pll_cfg_t;

	typedef enum logic {
		VIDEO_57HZ,
		VIDEO_60HZ
	} video_timing_e;

	////////////////////
	// PS/2 set 2 scan codes
	////////////////////
	localparam logic [7:0] KEY_START1 = 8'h16;
	localparam logic [7:0] KEY_START2 = 8'h1E;
	localparam logic [7:0] KEY_COIN1 = 8'h2E;
	localparam logic [7:0] KEY_COIN2 = 8'h36;
	localparam logic [7:0] KEY_SERVICE = 8'h46;
	localparam logic [7:0] KEY_PAUSE = 8'h4D;
	localparam logic [7:0] KEY_UP = 8'h75;
	localparam logic [7:0] KEY_DOWN = 8'h72;
	localparam logic [7:0] KEY_LEFT = 8'h6B;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_CTRL = 8'h14;
	localparam logic [7:0] KEY_ALT = 8'h11;

	////////////////////
	// PLL reconfig tables
	////////////////////
	// Mode, M, N, C0, C1, charge pump, bandwidth, M fraction, start
	localparam pll_cfg_t PLL_TABLE_57 [PLL_PARAM_COUNT] = '{
		'{6'h00, 32'h0000_0000}, '{6'h04, 32'h0002_0504}, '{6'h03, 32'h0001_0000},
		'{6'h05, 32'h0000_0505}, '{6'h05, 32'h0006_0302}, '{6'h09, 32'h0000_0002},
		'{6'h08, 32'h0000_0007}, '{6'h07, 32'h9999_999A}, '{6'h02, 32'h0000_0001}
	};
	// Same order, fractional M for the 60 Hz master clock
	localparam pll_cfg_t PLL_TABLE_60 [PLL_PARAM_COUNT] = '{
		'{6'h00, 32'h0000_0000}, '{6'h04, 32'h0000_0A0A}, '{6'h03, 32'h0001_0000},
		'{6'h05, 32'h0000_0A0A}, '{6'h05, 32'h0004_0505}, '{6'h09, 32'h0000_0002},
		'{6'h08, 32'h0000_0007}, '{6'h07, 32'h0DD3_FDC4}, '{6'h02, 32'h0000_0001}
	};

endpackage

`default_nettype wire

// File: verilog/xsleena_io.sv
/* Cabinet-side control block: keyboard, per-player input merge, port bytes,
   DIP capture and PLL reprogramming, all on MS_CLK. */
`timescale 1ns/1ps
`default_nettype none

module xsleena_io (
	input wire logic MS_CLK,
	input wire logic reset,
	input xs_pkg::joy_word_t joystick_0,
	input xs_pkg::joy_word_t joystick_1,
	input xs_pkg::joy_word_t db15_1,
	input xs_pkg::joy_word_t db15_2,
	input wire logic [1:0] snac_dev,
	input xs_pkg::ps2_key_t ps2_key,
	input xs_pkg::dl_write_t dl,
	input xs_pkg::video_timing_e timing_sel,
	input wire logic pll_locked,
	input wire logic cfg_ack,
	output xs_pkg::port_byte_t player1,
	output xs_pkg::port_byte_t player2,
	output logic pause_btn,
	output xs_pkg::port_byte_t dsw1,
	output xs_pkg::port_byte_t dsw2,
	output xs_pkg::pll_cfg_t cfg,
	output logic cfg_req,
	output logic reconfig_pause,
	output logic init_done
);

	xs_pkg::key_player_t [xs_pkg::NUM_PLAYERS-1:0] key_player;
	xs_pkg::pressed_t [xs_pkg::NUM_PLAYERS-1:0] pressed;
	xs_pkg::joy_word_t [xs_pkg::NUM_PLAYERS-1:0] joy_words;
	xs_pkg::joy_word_t [xs_pkg::NUM_PLAYERS-1:0] db_words;

	// Index by player for the merge loop
	assign joy_words = {joystick_1, joystick_0};
	assign db_words = {db15_2, db15_1};

	////////////////////
	// Input path
	////////////////////
	key_decoder i_key_decoder (
		.MS_CLK(MS_CLK),
		.reset(reset),
		.ps2_key(ps2_key),
		.key_player(key_player)
	);

	for (genvar p = 0; p < xs_pkg::NUM_PLAYERS; p++) begin : g_player
		player_merge i_player_merge (
			.MS_CLK(MS_CLK),
			.reset(reset),
			.key_in(key_player[p]),
			.joystick(joy_words[p]),
			.db15(db_words[p]),
			.db_enable(snac_dev[p]),
			.pressed(pressed[p])
		);
	end

	cabinet_ports i_cabinet_ports (
		.MS_CLK(MS_CLK),
		.reset(reset),
		.pressed(pressed),
		.player1(player1),
		.player2(player2),
		.pause_btn(pause_btn)
	);

	////////////////////
	// DIP and PLL
	////////////////////
	dip_capture i_dip_capture (
		.MS_CLK(MS_CLK),
		.reset(reset),
		.dl(dl),
		.dsw1(dsw1),
		.dsw2(dsw2)
	);

	pll_reprogram i_pll_reprogram (
		.MS_CLK(MS_CLK),
		.reset(reset),
		.timing_sel(timing_sel),
		.pll_locked(pll_locked),
		.cfg(cfg),
		.cfg_req(cfg_req),
		.cfg_ack(cfg_ack),
		.reconfig_pause(reconfig_pause),
		.init_done(init_done)
	);

endmodule

`default_nettype wire
